// File: project.f
+incdir+.
spin_pkg.sv
spin_stream_if.sv
spin_fifo.sv
spin_fifo_maintainer.sv
spin_iteration_engine.sv
spin_readout_packer.sv
spin_top.sv
tb_spin_top.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the spin buffer testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/10ps -f project.f \
    --top-module tb_spin_top -o tb_spin_top
status=$?
if [ "$status" -ne 0 ]; then
    echo "Verilator build failed"
    exit "$status"
fi

./obj_dir/tb_spin_top
status=$?
if [ "$status" -ne 0 ]; then
    echo "Simulation failed"
    exit "$status"
fi

exit 0

// File: spin_config.svh
`ifndef SPIN_CONFIG_SVH
`define SPIN_CONFIG_SVH

// Number of spins in one vector
`define SPIN_NUM 16

// Entries in the spin FIFO
`define SPIN_FIFO_DEPTH 4

// Host word width
// Must divide SPIN_NUM evenly
`define SPIN_HOST_WIDTH 8

// Iteration counter width
`define SPIN_ITER_WIDTH 8

`endif

// File: spin_fifo.sv
`timescale 1ns/10ps
`default_nettype none

`include "spin_config.svh"

module spin_fifo import spin_pkg::*; (
    input  logic        clk_i,
    input  logic        reset_i,
    input  logic        flush_i,
    input  logic        push_i,
    input  logic        push_none_i,
    input  spin_vec_t   data_i,
    input  logic        pop_i,
    output spin_vec_t   data_o,
    output logic        full_o,
    output logic        empty_o,
    output spin_usage_t usage_o
);

    localparam int unsigned DEPTH = `SPIN_FIFO_DEPTH;
    localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    // Storage array
    spin_vec_t        mem_q [DEPTH];
    logic [PTR_W-1:0] wr_ptr_q;
    logic [PTR_W-1:0] rd_ptr_q;
    spin_usage_t      usage_q;
    // Copy of the most recent write for repeat pushes
    spin_vec_t        last_q;
    spin_vec_t        wr_data;
    logic             push_en;
    logic             pop_en;

    // Pointer increment with wrap at the last entry
    function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] ptr);
        if (ptr == PTR_W'(DEPTH - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    // Status straight from the occupancy counter
    assign full_o  = (usage_q == spin_usage_t'(DEPTH));
    assign empty_o = (usage_q == '0);
    assign usage_o = usage_q;

    // Head of queue from registered storage with no fall-through
    assign data_o = mem_q[rd_ptr_q];

    // Push while full is dropped and pop while empty is ignored
    assign push_en = push_i & ~full_o;
    assign pop_en  = pop_i & ~empty_o;

    // Repeat push writes the previous vector again
    assign wr_data = push_none_i ? last_q : data_i;

    // Pointers, counter and last vector
    always_ff @(posedge clk_i) begin
        if (reset_i || flush_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            usage_q  <= '0;
            last_q   <= '0;
        end else begin
            if (push_en) begin
                wr_ptr_q <= ptr_next(wr_ptr_q);
                last_q   <= wr_data;
            end
            if (pop_en) begin
                rd_ptr_q <= ptr_next(rd_ptr_q);
            end
            // Occupancy only moves when exactly one side fires
            case ({push_en, pop_en})
                2'b10:   usage_q <= usage_q + 1'b1;
                2'b01:   usage_q <= usage_q - 1'b1;
                default: usage_q <= usage_q;
            endcase
        end
    end

    // Memory write port
    always_ff @(posedge clk_i) begin
        if (push_en) begin
            mem_q[wr_ptr_q] <= wr_data;
        end
    end

endmodule

`default_nettype wire

// File: spin_fifo_maintainer.sv
`timescale 1ns/10ps
`default_nettype none

module spin_fifo_maintainer import spin_pkg::*; (
    input  logic          clk_i,
    input  logic          reset_i,
    input  logic          en_i,
    input  logic          flush_i,
    input  logic          cmpt_en_i,
    input  logic          host_readout_i,
    input  logic          iter_finish_i,
    spin_stream_if.sink   push,
    spin_stream_if.source pop,
    output logic          cmpt_busy_o,
    output spin_usage_t   fifo_usage_o
);

    logic fifo_full;
    logic fifo_empty;
    logic fifo_push;
    logic fifo_pop;
    // Completion status register
    logic cmpt_busy_q;
    logic cmpt_stop;
    logic cmpt_set;
    logic cmpt_clr;

    // Spin storage
    spin_fifo spin_fifo_inst (
        .clk_i       (clk_i),
        .reset_i     (reset_i),
        .flush_i     (flush_i),
        .push_i      (fifo_push),
        .push_none_i (push.none),
        .data_i      (push.data),
        .pop_i       (fifo_pop),
        .data_o      (pop.data),
        .full_o      (fifo_full),
        .empty_o     (fifo_empty),
        .usage_o     (fifo_usage_o)
    );

    // Engine is done and nothing more fits
    assign cmpt_stop = iter_finish_i & fifo_full;

    // Push side only needs room
    assign push.ready = ~fifo_full;
    assign fifo_push  = push.valid & push.ready;

    // Pops during a live run, or any time the host reads out
    assign pop.valid = en_i & ~fifo_empty
                     & ((cmpt_busy_q & ~iter_finish_i) | host_readout_i);
    assign fifo_pop  = pop.valid & pop.ready;
    // Outgoing vectors always carry real data
    assign pop.none  = 1'b0;

    assign cmpt_set = cmpt_en_i & en_i;
    assign cmpt_clr = cmpt_stop | flush_i;

    // Clear wins over set
    always_ff @(posedge clk_i) begin
        if (reset_i || cmpt_clr) begin
            cmpt_busy_q <= 1'b0;
        end else if (cmpt_set) begin
            cmpt_busy_q <= 1'b1;
        end
    end

    assign cmpt_busy_o = cmpt_busy_q;

endmodule

`default_nettype wire

// File: spin_iteration_engine.sv
`timescale 1ns/10ps
`default_nettype none

`include "spin_config.svh"

module spin_iteration_engine import spin_pkg::*; (
    input  logic          clk_i,
    input  logic          reset_i,
    input  logic          flush_i,
    input  logic          start_i,
    input  spin_vec_t     init_spin_i,
    input  spin_iter_t    num_iter_i,
    input  spin_vec_t     flip_mask_i,
    spin_stream_if.source push,
    output logic          iter_finish_o
);

    localparam int unsigned POS_W = (`SPIN_NUM > 1) ? $clog2(`SPIN_NUM) : 1;

    engine_state_e    state_q;
    // Vector of the previous iteration
    spin_vec_t        base_q;
    spin_vec_t        mask_q;
    spin_iter_t       iter_q;
    spin_iter_t       total_q;
    // Spin position, (k - 1) mod SPIN_NUM
    logic [POS_W-1:0] pos_q;
    logic             flip;
    logic             first_iter;
    spin_vec_t        flip_bit;
    logic             push_fire;
    logic             start_ok;

    assign flip       = mask_q[pos_q];
    assign flip_bit   = spin_vec_t'(1) << pos_q;
    assign first_iter = (iter_q == spin_iter_t'(1));

    // Outgoing vector, held from registers until accepted
    assign push.valid = (state_q == ENGINE_RUN);
    assign push.data  = flip ? (base_q ^ flip_bit) : base_q;
    // First vector goes out as data since the FIFO has no copy of the initial spin yet
    assign push.none  = ~flip & ~first_iter;

    assign push_fire     = push.valid & push.ready;
    assign iter_finish_o = (state_q == ENGINE_DONE);

    // Restart allowed from idle or after completion
    assign start_ok = start_i & (state_q != ENGINE_RUN);

    // FSM and iteration counters
    always_ff @(posedge clk_i) begin
        if (reset_i || flush_i) begin
            state_q <= ENGINE_IDLE;
            iter_q  <= '0;
            pos_q   <= '0;
        end else if (start_ok) begin
            iter_q  <= spin_iter_t'(1);
            pos_q   <= '0;
            // Zero iterations finish at once
            state_q <= (num_iter_i == '0) ? ENGINE_DONE : ENGINE_RUN;
        end else if (push_fire) begin
            if (iter_q == total_q) begin
                state_q <= ENGINE_DONE;
            end else begin
                iter_q <= iter_q + 1'b1;
                pos_q  <= (pos_q == POS_W'(`SPIN_NUM - 1)) ? '0 : pos_q + 1'b1;
            end
        end
    end

    // Run parameters and current vector
    always_ff @(posedge clk_i) begin
        if (start_ok) begin
            base_q  <= init_spin_i;
            mask_q  <= flip_mask_i;
            total_q <= num_iter_i;
        end else if (push_fire) begin
            base_q <= push.data;
        end
    end

endmodule

`default_nettype wire

// File: spin_pkg.sv
`default_nettype none

`include "spin_config.svh"

package spin_pkg;

    // One spin vector, bit i holds spin i
    typedef logic [`SPIN_NUM-1:0] spin_vec_t;

    // FIFO occupancy, 0 up to the full depth
    typedef logic [$clog2(`SPIN_FIFO_DEPTH):0] spin_usage_t;

    // Iteration count as loaded by the engine
    typedef logic [`SPIN_ITER_WIDTH-1:0] spin_iter_t;

    // One word on the host side
    typedef logic [`SPIN_HOST_WIDTH-1:0] host_word_t;

    // Iteration engine FSM
    typedef enum logic [1:0] {
        ENGINE_IDLE,
        ENGINE_RUN,
        ENGINE_DONE
    } engine_state_e;

    // Readout packer FSM
    typedef enum logic {
        PACK_IDLE,
        PACK_SEND
    } packer_state_e;

endpackage

`default_nettype wire

// File: spin_readout_packer.sv
`timescale 1ns/10ps
`default_nettype none

`include "spin_config.svh"

module spin_readout_packer import spin_pkg::*; (
    input  logic        clk_i,
    input  logic        reset_i,
    input  logic        flush_i,
    spin_stream_if.sink spin,
    output logic        host_valid_o,
    output host_word_t  host_data_o,
    input  logic        host_ready_i
);

    // Host words per spin vector
    localparam int unsigned WORDS = `SPIN_NUM / `SPIN_HOST_WIDTH;
    localparam int unsigned CNT_W = (WORDS > 1) ? $clog2(WORDS) : 1;

    packer_state_e    state_q;
    // Remaining words, lowest word in the bottom slice
    spin_vec_t        shift_q;
    logic [CNT_W-1:0] cnt_q;
    logic             spin_fire;
    logic             word_fire;
    logic             last_word;

    // One vector at a time
    assign spin.ready = (state_q == PACK_IDLE);
    assign spin_fire  = spin.valid & spin.ready;

    assign host_valid_o = (state_q == PACK_SEND);
    assign host_data_o  = shift_q[`SPIN_HOST_WIDTH-1:0];
    assign word_fire    = host_valid_o & host_ready_i;
    assign last_word    = (cnt_q == CNT_W'(WORDS - 1));

    // FSM and word counter
    always_ff @(posedge clk_i) begin
        if (reset_i || flush_i) begin
            // Any partial vector is dropped
            state_q <= PACK_IDLE;
            cnt_q   <= '0;
        end else begin
            case (state_q)
                PACK_IDLE: begin
                    if (spin_fire) begin
                        state_q <= PACK_SEND;
                        cnt_q   <= '0;
                    end
                end
                PACK_SEND: begin
                    if (word_fire) begin
                        if (last_word) begin
                            state_q <= PACK_IDLE;
                        end else begin
                            cnt_q <= cnt_q + 1'b1;
                        end
                    end
                end
                default: state_q <= PACK_IDLE;
            endcase
        end
    end

    // Load on accept, step down one word per host transfer
    always_ff @(posedge clk_i) begin
        if (spin_fire) begin
            shift_q <= spin.data;
        end else if (word_fire) begin
            shift_q <= shift_q >> `SPIN_HOST_WIDTH;
        end
    end

endmodule

`default_nettype wire

// File: spin_stream_if.sv
`timescale 1ns/10ps
`default_nettype none

interface spin_stream_if import spin_pkg::*; ();

    // Handshake, transfer when both high on a rising edge
    logic valid;
    logic ready;

    // Spin vector payload
    spin_vec_t data;

    // Repeat flag, FIFO stores its last written vector again
    logic none;

    // Producer side
    modport source (output valid, output data, output none, input ready);

    // Consumer side
    modport sink (input valid, input data, input none, output ready);

endinterface

`default_nettype wire

// File: spin_top.sv
`timescale 1ns/10ps
`default_nettype none

`include "spin_config.svh"

module spin_top (
    input  logic                              clk_i,
    input  logic                              reset_i,
    input  logic                              en_i,
    input  logic                              flush_i,
    input  logic                              cmpt_en_i,
    input  logic                              host_readout_i,
    input  logic                              start_i,
    input  logic [`SPIN_NUM-1:0]              init_spin_i,
    input  logic [`SPIN_NUM-1:0]              flip_mask_i,
    input  logic [`SPIN_ITER_WIDTH-1:0]       num_iter_i,
    input  logic                              host_ready_i,
    output logic                              host_valid_o,
    output logic [`SPIN_HOST_WIDTH-1:0]       host_data_o,
    output logic                              cmpt_busy_o,
    output logic                              iter_done_o,
    output logic [$clog2(`SPIN_FIFO_DEPTH):0] fifo_usage_o
);

    // Engine to FIFO, and FIFO to packer
    spin_stream_if push_stream ();
    spin_stream_if pop_stream ();

    logic iter_finish;

    spin_iteration_engine spin_iteration_engine_inst (
        .clk_i         (clk_i),
        .reset_i       (reset_i),
        .flush_i       (flush_i),
        .start_i       (start_i),
        .init_spin_i   (init_spin_i),
        .num_iter_i    (num_iter_i),
        .flip_mask_i   (flip_mask_i),
        .push          (push_stream.source),
        .iter_finish_o (iter_finish)
    );

    spin_fifo_maintainer spin_fifo_maintainer_inst (
        .clk_i          (clk_i),
        .reset_i        (reset_i),
        .en_i           (en_i),
        .flush_i        (flush_i),
        .cmpt_en_i      (cmpt_en_i),
        .host_readout_i (host_readout_i),
        .iter_finish_i  (iter_finish),
        .push           (push_stream.sink),
        .pop            (pop_stream.source),
        .cmpt_busy_o    (cmpt_busy_o),
        .fifo_usage_o   (fifo_usage_o)
    );

    spin_readout_packer spin_readout_packer_inst (
        .clk_i        (clk_i),
        .reset_i      (reset_i),
        .flush_i      (flush_i),
        .spin         (pop_stream.sink),
        .host_valid_o (host_valid_o),
        .host_data_o  (host_data_o),
        .host_ready_i (host_ready_i)
    );

    // Done flag seen by the host
    assign iter_done_o = iter_finish;

endmodule

`default_nettype wire

// File: tb_spin_top.sv
`timescale 1ns/10ps
`default_nettype none

`include "spin_config.svh"

module tb_spin_top import spin_pkg::*; ();

    localparam int DEPTH      = `SPIN_FIFO_DEPTH;
    localparam int WORDS      = `SPIN_NUM / `SPIN_HOST_WIDTH;
    localparam int WAIT_LIMIT = 2000;
    localparam int NUM_TESTS  = 6;
    // How the host drains a run
    localparam logic [1:0] MODE_FREE  = 2'd0;
    localparam logic [1:0] MODE_STOP  = 2'd1;
    localparam logic [1:0] MODE_FLUSH = 2'd2;
    // Host ready patterns
    localparam logic [1:0] READY_LOW    = 2'd0;
    localparam logic [1:0] READY_HIGH   = 2'd1;
    localparam logic [1:0] READY_RANDOM = 2'd2;
    // Conditions a wait can end on
    localparam int UNTIL_DRAINED  = 0;
    localparam int UNTIL_STOPPED  = 1;
    localparam int UNTIL_BUSY_LOW = 2;
    localparam int UNTIL_FULL     = 3;

    typedef struct {
        string      name;
        spin_vec_t  init;
        spin_vec_t  mask;
        logic       rand_mask;
        spin_iter_t iters;
        logic [1:0] mode;
        logic [1:0] ready_pat;
    } test_t;

    logic        clk_i = 1'b0;
    logic        reset_i;
    logic        en_i;
    logic        flush_i;
    logic        cmpt_en_i;
    logic        host_readout_i;
    logic        start_i;
    spin_vec_t   init_spin_i;
    spin_vec_t   flip_mask_i;
    spin_iter_t  num_iter_i;
    logic        host_ready_i;
    logic        host_valid_o;
    logic        cmpt_busy_o;
    logic        iter_done_o;
    host_word_t  host_data_o;
    spin_usage_t fifo_usage_o;

    test_t       tests [NUM_TESTS];
    // Host words still due with the oldest first
    host_word_t  exp_q [$];
    string       cur_name;
    logic [31:0] lcg_state;

    spin_top spin_top_inst (.*);

    // 4 ns period
    always #2 clk_i = ~clk_i;

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    // Random pattern stalls about one cycle in four
    function automatic logic pick_ready(input logic [1:0] pattern);
        logic [31:0] r;
        r = lcg_next();
        case (pattern)
            READY_LOW:  return 1'b0;
            READY_HIGH: return 1'b1;
            default:    return r[17:16] != 2'b00;
        endcase
    endfunction

    task automatic abort_run();
        $display("Errors found");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic report_failure(input string msg);
        $display("%s: %s", cur_name, msg);
        abort_run();
    endtask

    task automatic check_value(input string what, input logic [31:0] exp,
                               input logic [31:0] act);
        if (exp !== act) begin
            $display("MISMATCH %s/%s expected 0x%0h actual 0x%0h", cur_name, what, exp, act);
            abort_run();
        end
    endtask

    // Iteration k flips spin (k-1) mod SPIN_NUM when its mask bit is set
    // Each vector then splits into host words with the low word first
    task automatic build_model(input spin_vec_t init, input spin_vec_t mask,
                               input spin_iter_t iters);
        spin_vec_t vec;
        spin_vec_t flip;
        vec = init;
        for (int k = 0; k < int'(iters); k++) begin
            flip = spin_vec_t'(1) << (k % `SPIN_NUM);
            if ((mask & flip) != '0) begin
                vec = vec ^ flip;
            end
            for (int w = 0; w < WORDS; w++) begin
                exp_q.push_back(host_word_t'(vec >> (w * `SPIN_HOST_WIDTH)));
            end
        end
    endtask

    // Drive host ready on the falling edge
    // Valid and ready here meet at the next rising edge
    task automatic clock_step(input logic ready);
        @(negedge clk_i);
        host_ready_i = ready;
        if (host_valid_o && ready) begin
            if (exp_q.size() == 0) begin
                report_failure("a host word arrived when none was expected");
            end else begin
                check_value("word", 32'(exp_q[0]), 32'(host_data_o));
                exp_q.delete(0);
            end
        end
    endtask

    function automatic logic reached(input int what);
        case (what)
            UNTIL_DRAINED:  return exp_q.size() == 0;
            UNTIL_STOPPED:  return iter_done_o && fifo_usage_o == spin_usage_t'(DEPTH);
            UNTIL_BUSY_LOW: return !cmpt_busy_o;
            default:        return fifo_usage_o == spin_usage_t'(DEPTH);
        endcase
    endfunction

    task automatic wait_until(input int what, input logic [1:0] pattern, input string msg);
        int n;
        n = 0;
        while (!reached(what) && n < WAIT_LIMIT) begin
            clock_step(pick_ready(pattern));
            // Completion can only end once the engine is done
            if (!iter_done_o) begin
                check_value("busy_run", 32'd1, 32'(cmpt_busy_o));
            end
            n++;
        end
        if (!reached(what)) begin
            report_failure($sformatf("timed out waiting for %s", msg));
        end
    endtask

    task automatic run_test(input test_t t);
        spin_vec_t   mask;
        logic [31:0] r;
        cur_name = t.name;
        r = lcg_next();
        mask = t.rand_mask ? r[31 -: `SPIN_NUM] : t.mask;
        build_model(t.init, mask, t.iters);
        init_spin_i = t.init;
        flip_mask_i = mask;
        num_iter_i = t.iters;
        host_readout_i = (t.mode == MODE_FREE);
        cmpt_en_i = 1'b1;
        clock_step(1'b0);
        cmpt_en_i = 1'b0;
        check_value("busy_rise", 32'd1, 32'(cmpt_busy_o));
        start_i = 1'b1;
        clock_step(1'b0);
        start_i = 1'b0;
        case (t.mode)
            MODE_FREE: begin
                wait_until(UNTIL_DRAINED, t.ready_pat, "all host words");
            end
            MODE_STOP: begin
                wait_until(UNTIL_STOPPED, READY_LOW, "iterations done with a full FIFO");
                wait_until(UNTIL_BUSY_LOW, READY_LOW, "completion to clear");
                // Packer empties its held vector and then pops stay gated
                for (int i = 0; i < 12; i++) begin
                    clock_step(1'b1);
                    if (i >= 6) begin
                        check_value("held", 32'd0, 32'(host_valid_o));
                    end
                end
                check_value("left_in_fifo", 32'(DEPTH * WORDS), 32'(exp_q.size()));
                host_readout_i = 1'b1;
                wait_until(UNTIL_DRAINED, t.ready_pat, "the host readout drain");
            end
            default: begin
                wait_until(UNTIL_FULL, READY_LOW, "the FIFO to fill");
                flush_i = 1'b1;
                clock_step(1'b0);
                flush_i = 1'b0;
                check_value("flush_usage", 32'd0, 32'(fifo_usage_o));
                check_value("flush_busy", 32'd0, 32'(cmpt_busy_o));
                check_value("flush_done", 32'd0, 32'(iter_done_o));
                check_value("flush_valid", 32'd0, 32'(host_valid_o));
                // Flushed vectors never reach the host
                exp_q.delete();
            end
        endcase
        // Catch words beyond the model
        repeat (6) clock_step(1'b1);
    endtask

    initial begin
        lcg_state = 32'd55;
        reset_i = 1'b1;
        en_i = 1'b0;
        flush_i = 1'b0;
        cmpt_en_i = 1'b0;
        host_readout_i = 1'b0;
        start_i = 1'b0;
        host_ready_i = 1'b0;
        init_spin_i = '0;
        flip_mask_i = '0;
        num_iter_i = '0;
        cur_name = "reset";
        tests[0] = '{"normal_run", spin_vec_t'(16'h3C5A), '1, 1'b0, spin_iter_t'(4),
                     MODE_FREE, READY_HIGH};
        tests[1] = '{"repeat_none", spin_vec_t'(16'h8001), spin_vec_t'(16'h0A0A), 1'b0,
                     spin_iter_t'(6), MODE_FREE, READY_HIGH};
        tests[2] = '{"backpressure", '0, '0, 1'b1, spin_iter_t'(20), MODE_FREE, READY_RANDOM};
        tests[3] = '{"stop_drain", spin_vec_t'(16'h0F0F), '0, 1'b1, spin_iter_t'(DEPTH + 1),
                     MODE_STOP, READY_HIGH};
        tests[4] = '{"flush_mid", spin_vec_t'(16'h1234), '1, 1'b0, spin_iter_t'(12),
                     MODE_FLUSH, READY_HIGH};
        tests[5] = '{"after_flush", spin_vec_t'(16'hBEEF), '0, 1'b1, spin_iter_t'(9),
                     MODE_FREE, READY_RANDOM};
        repeat (4) clock_step(1'b0);
        reset_i = 1'b0;
        // Idle outputs right after reset
        for (int i = 0; i < 3; i++) begin
            clock_step(1'b0);
            check_value("host_valid", 32'd0, 32'(host_valid_o));
            check_value("cmpt_busy", 32'd0, 32'(cmpt_busy_o));
            check_value("iter_done", 32'd0, 32'(iter_done_o));
            check_value("fifo_usage", 32'd0, 32'(fifo_usage_o));
        end
        en_i = 1'b1;
        for (int i = 0; i < NUM_TESTS; i++) begin
            run_test(tests[i]);
        end
        $display("No errors");
        $finish;
    end

endmodule

`default_nettype wire
